//--- conv_pkg.sv
package conv_pkg;

  localparam int DATA_WIDTH = 32; // memory data width
  localparam int ELEM_WIDTH = 8;  // weight and ifm element width
  localparam int ACC_SHIFT  = 9;  // fixed point scale before the partial add
  localparam int ADDR_WIDTH = 32; // address width carried in the read request

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic signed [ELEM_WIDTH-1:0] elem_t;

  typedef enum logic [2:0] {
    IDLE          = 3'd0,
    FETCH_OFM     = 3'd1,
    FETCH_WT      = 3'd2,
    FETCH_IFM     = 3'd3,
    COMPUTE       = 3'd4,
    WRITE_OFM_REQ = 3'd5,
    WRITE_OFM     = 3'd6,
    DONE          = 3'd7
  } conv_state_e;

  // access size code as log2 of the byte count
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd0,
    SIZE_WORD = 3'd2
  } mem_size_e;

  typedef struct packed {
    word_t ifm_dim;
    word_t ifm_depth;
    word_t ofm_dim;
    word_t ofm_depth;
  } conv_job_t;

  typedef struct packed {
    word_t ifm_base;
    word_t wt_base;
    word_t ofm_base;
  } conv_base_t;

  typedef struct packed {
    word_t ifm_size;  // ifm_dim squared
    word_t ofm_size;  // ofm_dim squared
    word_t wt_volume; // kernel size times ifm_depth
  } conv_geom_t;

  // single cycle strobes from the controller
  typedef struct packed {
    logic rd_fire;
    logic wr_fire;
    logic row_wrap;     // window column wraps
    logic window_last;  // last window element fetched
    logic ofm_row_done;
    logic plane_done;   // one conv2D finished
    logic oc_step;      // plane done in the last input channel
  } conv_evt_t;

  typedef struct packed {
    word_t window_x;
    word_t window_y;
    word_t ofm_x;
  } conv_pos_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    mem_size_e             size;
  } mem_rd_req_t;

endpackage

//--- conv_shape.sv
`timescale 1ns/1ps

module conv_shape #(
  parameter int WT_DIM = 5
) (
  input  logic                 clk,
  input  conv_pkg::conv_job_t  job,
  output conv_pkg::conv_geom_t geom
);

  localparam int WT_SIZE = WT_DIM * WT_DIM;

  localparam conv_pkg::word_t WT_SIZE_W = conv_pkg::word_t'(WT_SIZE);

  // products registered here so the address adders only see sums
  always_ff @(posedge clk) begin
    geom.ifm_size  <= job.ifm_dim * job.ifm_dim;
    geom.ofm_size  <= job.ofm_dim * job.ofm_dim;
    geom.wt_volume <= WT_SIZE_W * job.ifm_depth;
  end

endmodule

//--- conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl #(
  parameter int WT_DIM = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  conv_pkg::conv_job_t   job,
  input  logic                  rd_data_valid,
  output logic                  rd_data_ready,
  output logic                  rd_req_valid,
  output logic                  wr_req_valid,
  input  logic                  wr_req_ready,
  output logic                  wr_data_valid,
  input  logic                  wr_data_ready,
  output conv_pkg::conv_state_e state,
  output conv_pkg::conv_evt_t   evt,
  output conv_pkg::conv_pos_t   pos,
  output logic                  ic_first,
  output logic                  done,
  output logic                  idle
);

  localparam int WT_SIZE = WT_DIM * WT_DIM;

  localparam conv_pkg::word_t WT_LAST    = conv_pkg::word_t'(WT_DIM - 1);
  localparam conv_pkg::word_t SHIFT_LAST = conv_pkg::word_t'(WT_SIZE - 1);

  conv_pkg::conv_state_e state_next;

  conv_pkg::word_t win_x;
  conv_pkg::word_t win_y;
  conv_pkg::word_t shift_cnt;
  conv_pkg::word_t ofm_x_cnt;
  conv_pkg::word_t ofm_y_cnt;
  conv_pkg::word_t ic_cnt;
  conv_pkg::word_t oc_cnt;

  logic fetching;    // weight or ifm fetch
  logic wr_req_fire;
  logic shift_done;
  logic last_oc;
  logic done_q;

  assign fetching    = (state == conv_pkg::FETCH_WT) || (state == conv_pkg::FETCH_IFM);
  assign wr_req_fire = wr_req_valid & wr_req_ready;
  assign shift_done  = (state == conv_pkg::COMPUTE) && (shift_cnt == SHIFT_LAST);
  assign last_oc     = oc_cnt == job.ofm_depth - 1'b1;

  always_comb begin
    evt.rd_fire      = rd_data_valid & rd_data_ready;
    evt.wr_fire      = wr_data_valid & wr_data_ready;
    evt.row_wrap     = fetching & evt.rd_fire & (win_x == WT_LAST);
    evt.window_last  = evt.row_wrap & (win_y == WT_LAST);
    evt.ofm_row_done = (state == conv_pkg::WRITE_OFM) & evt.wr_fire &
                       (ofm_x_cnt == job.ofm_dim - 1'b1);
    evt.plane_done   = evt.ofm_row_done & (ofm_y_cnt == job.ofm_dim - 1'b1);
    evt.oc_step      = evt.plane_done & (ic_cnt == job.ifm_depth - 1'b1);
  end

  always_comb begin
    state_next = state;
    case (state)
      conv_pkg::IDLE: begin
        if (start) state_next = conv_pkg::FETCH_WT; // no partial to read yet
      end
      conv_pkg::FETCH_OFM: begin
        if (evt.rd_fire) state_next = conv_pkg::FETCH_WT;
      end
      conv_pkg::FETCH_WT: begin
        if (evt.window_last) state_next = conv_pkg::FETCH_IFM;
      end
      conv_pkg::FETCH_IFM: begin
        if (evt.window_last) state_next = conv_pkg::COMPUTE;
      end
      conv_pkg::COMPUTE: begin
        if (shift_done) state_next = conv_pkg::WRITE_OFM_REQ;
      end
      conv_pkg::WRITE_OFM_REQ: begin
        if (wr_req_fire) state_next = conv_pkg::WRITE_OFM;
      end
      conv_pkg::WRITE_OFM: begin
        if (evt.wr_fire) begin
          if (evt.oc_step && last_oc) begin
            state_next = conv_pkg::DONE;
          end else if (ic_first && !evt.plane_done) begin
            state_next = conv_pkg::FETCH_IFM; // weights still held and no partial yet
          end else if (evt.oc_step) begin
            state_next = conv_pkg::FETCH_WT;
          end else begin
            state_next = conv_pkg::FETCH_OFM;
          end
        end
      end
      default: state_next = conv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= conv_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // loop nest counters are held while a port stalls
  always_ff @(posedge clk) begin
    if (!rst_n || state == conv_pkg::IDLE) begin
      win_x     <= '0;
      win_y     <= '0;
      shift_cnt <= '0;
      ofm_x_cnt <= '0;
      ofm_y_cnt <= '0;
      ic_cnt    <= '0;
      oc_cnt    <= '0;
    end else begin
      if (evt.row_wrap) win_x <= '0;
      else if (fetching && evt.rd_fire) win_x <= win_x + 1'b1;

      if (evt.window_last) win_y <= '0;
      else if (evt.row_wrap) win_y <= win_y + 1'b1;

      if (shift_done) shift_cnt <= '0;
      else if (state == conv_pkg::COMPUTE) shift_cnt <= shift_cnt + 1'b1;

      if (evt.ofm_row_done) ofm_x_cnt <= '0;
      else if (state == conv_pkg::WRITE_OFM && evt.wr_fire) ofm_x_cnt <= ofm_x_cnt + 1'b1;

      if (evt.plane_done) ofm_y_cnt <= '0;
      else if (evt.ofm_row_done) ofm_y_cnt <= ofm_y_cnt + 1'b1;

      if (evt.oc_step) ic_cnt <= '0;
      else if (evt.plane_done) ic_cnt <= ic_cnt + 1'b1;

      if (evt.oc_step) oc_cnt <= oc_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || (state == conv_pkg::IDLE && start)) begin
      done_q <= 1'b0;
    end else if (state == conv_pkg::DONE) begin
      done_q <= 1'b1;
    end
  end

  assign pos = '{window_x: win_x, window_y: win_y, ofm_x: ofm_x_cnt};

  assign ic_first      = ic_cnt == '0;
  assign done          = done_q & ~start;
  assign idle          = state == conv_pkg::IDLE;
  assign rd_req_valid  = fetching || (state == conv_pkg::FETCH_OFM);
  assign rd_data_ready = rd_req_valid;
  assign wr_req_valid  = state == conv_pkg::WRITE_OFM_REQ;
  assign wr_data_valid = state == conv_pkg::WRITE_OFM;

endmodule

//--- conv_addr_gen.sv
`timescale 1ns/1ps

module conv_addr_gen #(
  parameter int WT_DIM     = 5,
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  conv_pkg::conv_state_e state,
  input  conv_pkg::conv_evt_t   evt,
  input  conv_pkg::conv_pos_t   pos,
  input  conv_pkg::conv_geom_t  geom,
  input  conv_pkg::conv_job_t   job,
  input  conv_pkg::conv_base_t  base,
  output conv_pkg::mem_rd_req_t rd_req,
  output conv_pkg::word_t       wr_addr
);

  localparam int WT_SIZE = WT_DIM * WT_DIM;

  localparam conv_pkg::word_t WT_DIM_W  = conv_pkg::word_t'(WT_DIM);
  localparam conv_pkg::word_t WT_SIZE_W = conv_pkg::word_t'(WT_SIZE);
  localparam conv_pkg::word_t WT_LAST   = conv_pkg::word_t'(WT_DIM - 1);
  localparam conv_pkg::word_t ADDR_MASK = conv_pkg::word_t'((64'd1 << ADDR_WIDTH) - 64'd1);

  conv_pkg::word_t wt_plane_off;  // oc * wt_volume
  conv_pkg::word_t wt_ch_off;     // ic * WT_SIZE
  conv_pkg::word_t ifm_plane_off; // ic * ifm_size
  conv_pkg::word_t ifm_row_off;   // oy * ifm_dim
  conv_pkg::word_t ofm_plane_off; // oc * ofm_size
  conv_pkg::word_t ofm_row_off;   // oy * ofm_dim
  conv_pkg::word_t ifm_idx;       // wy * ifm_dim + wx

  conv_pkg::word_t wt_addr;
  conv_pkg::word_t ifm_addr;
  conv_pkg::word_t ofm_addr;

  always_ff @(posedge clk) begin
    if (!rst_n || state == conv_pkg::IDLE) begin
      wt_plane_off  <= '0;
      wt_ch_off     <= '0;
      ifm_plane_off <= '0;
      ifm_row_off   <= '0;
      ofm_plane_off <= '0;
      ofm_row_off   <= '0;
      ifm_idx       <= '0;
    end else begin
      if (evt.oc_step) begin
        wt_plane_off  <= wt_plane_off + geom.wt_volume;
        ofm_plane_off <= ofm_plane_off + geom.ofm_size;
      end

      if (evt.oc_step) wt_ch_off <= '0;
      else if (evt.plane_done) wt_ch_off <= wt_ch_off + WT_SIZE_W;

      if (evt.oc_step) ifm_plane_off <= '0;
      else if (evt.plane_done) ifm_plane_off <= ifm_plane_off + geom.ifm_size;

      if (evt.plane_done) begin
        ifm_row_off <= '0;
        ofm_row_off <= '0;
      end else if (evt.ofm_row_done) begin
        ifm_row_off <= ifm_row_off + job.ifm_dim;
        ofm_row_off <= ofm_row_off + job.ofm_dim;
      end

      // jump to the next ifm row at the end of a window row
      if (evt.window_last) begin
        ifm_idx <= '0;
      end else if (state == conv_pkg::FETCH_IFM && evt.rd_fire) begin
        ifm_idx <= evt.row_wrap ? ifm_idx + job.ifm_dim - WT_LAST : ifm_idx + 1'b1;
      end
    end
  end

  assign wt_addr  = base.wt_base + wt_plane_off + wt_ch_off +
                    pos.window_y * WT_DIM_W + pos.window_x;
  assign ifm_addr = base.ifm_base + ifm_plane_off + ifm_row_off + pos.ofm_x + ifm_idx;
  assign ofm_addr = base.ofm_base + ((ofm_plane_off + ofm_row_off + pos.ofm_x) << 2);

  always_comb begin
    case (state)
      conv_pkg::FETCH_OFM: begin
        rd_req.addr = ofm_addr & ADDR_MASK;
        rd_req.size = conv_pkg::SIZE_WORD;
      end
      conv_pkg::FETCH_WT: begin
        rd_req.addr = wt_addr & ADDR_MASK;
        rd_req.size = conv_pkg::SIZE_BYTE;
      end
      default: begin
        rd_req.addr = ifm_addr & ADDR_MASK;
        rd_req.size = conv_pkg::SIZE_BYTE;
      end
    endcase
  end

  assign wr_addr = ofm_addr & ADDR_MASK;

endmodule

//--- conv_window.sv
`timescale 1ns/1ps

module conv_window #(
  parameter int WT_DIM = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  conv_pkg::conv_state_e state,
  input  conv_pkg::conv_evt_t   evt,
  input  conv_pkg::mem_rd_req_t rd_req,
  input  conv_pkg::word_t       rd_data,
  output conv_pkg::elem_t       wt_head,
  output conv_pkg::elem_t       ifm_head
);

  localparam int WT_SIZE = WT_DIM * WT_DIM;
  localparam int EW      = conv_pkg::ELEM_WIDTH;

  conv_pkg::elem_t wt_sr  [WT_SIZE];
  conv_pkg::elem_t ifm_sr [WT_SIZE];
  conv_pkg::elem_t lane_byte;

  logic wt_load;
  logic ifm_load;
  logic rotate;

  // little endian lanes with address 0 in bits 7:0
  assign lane_byte = conv_pkg::elem_t'(rd_data[EW * rd_req.addr[1:0] +: EW]);

  assign wt_load  = (state == conv_pkg::FETCH_WT) && evt.rd_fire;
  assign ifm_load = (state == conv_pkg::FETCH_IFM) && evt.rd_fire;
  assign rotate   = state == conv_pkg::COMPUTE;

  always_ff @(posedge clk) begin
    if (!rst_n || state == conv_pkg::IDLE) begin
      for (int i = 0; i < WT_SIZE; i++) begin
        wt_sr[i]  <= '0;
        ifm_sr[i] <= '0;
      end
    end else begin
      if (wt_load || rotate) begin
        for (int i = 0; i < WT_SIZE - 1; i++) wt_sr[i] <= wt_sr[i+1];
        wt_sr[WT_SIZE-1] <= wt_load ? lane_byte : wt_sr[0]; // new byte in at the tail
      end
      if (ifm_load || rotate) begin
        for (int i = 0; i < WT_SIZE - 1; i++) ifm_sr[i] <= ifm_sr[i+1];
        ifm_sr[WT_SIZE-1] <= ifm_load ? lane_byte : ifm_sr[0];
      end
    end
  end

  // a full rotation returns the weights to their fetch order
  assign wt_head  = wt_sr[0];
  assign ifm_head = ifm_sr[0];

endmodule

//--- conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
  input  logic                  clk,
  input  logic                  rst_n,
  input  conv_pkg::conv_state_e state,
  input  conv_pkg::conv_evt_t   evt,
  input  logic                  ic_first,
  input  conv_pkg::word_t       rd_data,
  input  conv_pkg::elem_t       wt_head,
  input  conv_pkg::elem_t       ifm_head,
  output conv_pkg::word_t       wr_data
);

  localparam int PW = 2 * conv_pkg::ELEM_WIDTH;

  logic signed [conv_pkg::DATA_WIDTH-1:0] acc;
  logic signed [PW-1:0]                   product;
  conv_pkg::word_t                        partial; // ofm word read back

  assign product = wt_head * ifm_head;

  always_ff @(posedge clk) begin
    if (!rst_n || state == conv_pkg::IDLE || state == conv_pkg::FETCH_IFM) begin
      acc <= '0;
    end else if (state == conv_pkg::COMPUTE) begin
      acc <= acc + product; // sign extended
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || state == conv_pkg::IDLE || evt.oc_step) begin
      partial <= '0;
    end else if (state == conv_pkg::FETCH_OFM && evt.rd_fire) begin
      partial <= rd_data;
    end
  end

  // first input channel starts the ofm word from zero
  assign wr_data = (ic_first ? '0 : partial) +
                   conv_pkg::word_t'(acc >>> conv_pkg::ACC_SHIFT);

endmodule

//--- conv_accel.sv
`timescale 1ns/1ps

module conv_accel #(
  parameter int WT_DIM     = 5,
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,

  output logic                  rd_req_valid,
  input  logic                  rd_req_ready,
  output conv_pkg::mem_rd_req_t rd_req,
  input  conv_pkg::word_t       rd_data,
  input  logic                  rd_data_valid,
  output logic                  rd_data_ready,

  output logic                  wr_req_valid,
  input  logic                  wr_req_ready,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output conv_pkg::word_t       wr_data,
  output logic                  wr_data_valid,
  input  logic                  wr_data_ready,

  input  logic                  start,
  input  conv_pkg::conv_job_t   job,
  input  conv_pkg::conv_base_t  base,
  output logic                  done,
  output logic                  idle
);

  conv_pkg::conv_geom_t  geom;
  conv_pkg::conv_state_e state;
  conv_pkg::conv_evt_t   evt;
  conv_pkg::conv_pos_t   pos;
  conv_pkg::elem_t       wt_head;
  conv_pkg::elem_t       ifm_head;
  conv_pkg::word_t       wr_addr_full;
  logic                  ic_first;

  conv_shape #(
    .WT_DIM (WT_DIM)
  ) i_shape (
    .clk  (clk),
    .job  (job),
    .geom (geom)
  );

  // one request per data beat, so request acceptance follows from the data side
  conv_ctrl #(
    .WT_DIM (WT_DIM)
  ) i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .job           (job),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .rd_req_valid  (rd_req_valid),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .state         (state),
    .evt           (evt),
    .pos           (pos),
    .ic_first      (ic_first),
    .done          (done),
    .idle          (idle)
  );

  conv_addr_gen #(
    .WT_DIM     (WT_DIM),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (state),
    .evt     (evt),
    .pos     (pos),
    .geom    (geom),
    .job     (job),
    .base    (base),
    .rd_req  (rd_req),
    .wr_addr (wr_addr_full)
  );

  conv_window #(
    .WT_DIM (WT_DIM)
  ) i_window (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .evt      (evt),
    .rd_req   (rd_req),
    .rd_data  (rd_data),
    .wt_head  (wt_head),
    .ifm_head (ifm_head)
  );

  conv_mac i_mac (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .evt      (evt),
    .ic_first (ic_first),
    .rd_data  (rd_data),
    .wt_head  (wt_head),
    .ifm_head (ifm_head),
    .wr_data  (wr_data)
  );

  assign wr_addr = wr_addr_full[ADDR_WIDTH-1:0];

endmodule

//--- tb_conv_mem.sv
`timescale 1ns/1ps

module tb_conv_mem #(
  parameter int MEM_BYTES = 1024
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [3:0]            stall,  // rd req, rd data, wr req, wr data
  input  logic                  rd_req_valid,
  output logic                  rd_req_ready = 1'b0,
  input  conv_pkg::mem_rd_req_t rd_req,
  output conv_pkg::word_t       rd_data = '0,
  output logic                  rd_data_valid = 1'b0,
  input  logic                  rd_data_ready,
  input  logic                  wr_req_valid,
  output logic                  wr_req_ready = 1'b0,
  input  logic [31:0]           wr_addr,
  input  conv_pkg::word_t       wr_data,
  input  logic                  wr_data_valid,
  output logic                  wr_data_ready = 1'b0
);

  logic [7:0]  mem [MEM_BYTES];
  logic        rd_pend;
  logic        wr_pend;
  logic        rd_pend_next;
  logic        wr_pend_next;
  logic [31:0] wr_addr_q;

  // one outstanding request per direction
  assign rd_pend_next = (rd_pend || (rd_req_valid && rd_req_ready)) &&
                        !(rd_data_valid && rd_data_ready);
  assign wr_pend_next = (wr_pend || (wr_req_valid && wr_req_ready)) &&
                        !(wr_data_valid && wr_data_ready);

  // byte and word reads both return the aligned word
  function automatic conv_pkg::word_t word_at(input logic [31:0] addr);
    int a;
    a = int'({addr[31:2], 2'b00} % MEM_BYTES);
    return {mem[a+3], mem[a+2], mem[a+1], mem[a]};
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      rd_pend       <= 1'b0;
      wr_pend       <= 1'b0;
      rd_req_ready  <= 1'b0;
      rd_data_valid <= 1'b0;
      wr_req_ready  <= 1'b0;
      wr_data_ready <= 1'b0;
    end else begin
      rd_pend <= rd_pend_next;
      wr_pend <= wr_pend_next;
      if (rd_req_valid && rd_req_ready) rd_data <= word_at(rd_req.addr);
      if (wr_req_valid && wr_req_ready) wr_addr_q <= wr_addr;
      if (wr_data_valid && wr_data_ready) begin
        for (int i = 0; i < 4; i++) mem[(wr_addr_q + i) % MEM_BYTES] <= wr_data[8*i +: 8];
      end
      rd_req_ready  <= !rd_pend_next && !stall[0];
      rd_data_valid <= rd_pend_next && (rd_data_valid || !stall[1]); // held once raised
      wr_req_ready  <= !wr_pend_next && !stall[2];
      wr_data_ready <= wr_pend_next && !stall[3];
    end
  end

endmodule

//--- tb_conv_accel.sv
`timescale 1ns/1ps

module tb_conv_accel;

  localparam int WT_DIM      = 3;
  localparam int WT_SIZE     = WT_DIM * WT_DIM;
  localparam int CLK_NS      = 40;
  localparam int MEM_BYTES   = 1024;
  localparam int WORST_STALL = 8; // cycles allowed per handshake
  // pixel and input channel pairs over all jobs times the handshakes and compute of each
  localparam int TOTAL_BEATS = (9 + 27 + 36 + 36 + 18) * (2 * (2 * WT_SIZE + 2) + WT_SIZE);
  localparam int TIMEOUT_NS  = 2 * TOTAL_BEATS * WORST_STALL * CLK_NS + 20 * CLK_NS;

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  conv_pkg::conv_job_t   job;
  conv_pkg::conv_base_t  base;
  logic                  rd_req_valid;
  logic                  rd_req_ready;
  conv_pkg::mem_rd_req_t rd_req;
  conv_pkg::word_t       rd_data;
  logic                  rd_data_valid;
  logic                  rd_data_ready;
  logic                  wr_req_valid;
  logic                  wr_req_ready;
  logic [31:0]           wr_addr;
  conv_pkg::word_t       wr_data;
  logic                  wr_data_valid;
  logic                  wr_data_ready;
  logic                  done;
  logic                  idle;
  logic [3:0]            stall;

  logic [31:0]     lfsr = 32'd74135;
  logic            stall_en;
  logic            job_ran;
  int              wr_count;
  conv_pkg::word_t ofm_lo;
  conv_pkg::word_t ofm_hi;
  conv_pkg::word_t exp_words [64];
  conv_pkg::word_t prev_words [64];

  conv_accel #(
    .WT_DIM     (WT_DIM),
    .ADDR_WIDTH (32)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_req        (rd_req),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .start         (start),
    .job           (job),
    .base          (base),
    .done          (done),
    .idle          (idle)
  );

  tb_conv_mem #(
    .MEM_BYTES (MEM_BYTES)
  ) i_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_req        (rd_req),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("the run timed out after %0d ns before all tests finished", TIMEOUT_NS);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  // galois form with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [7:0] lfsr_byte();
    logic [7:0] v;
    for (int i = 0; i < 8; i++) v[i] = lfsr_bit();
    return v;
  endfunction

  function automatic conv_pkg::word_t read_word(input conv_pkg::word_t addr);
    return {i_mem.mem[addr+3], i_mem.mem[addr+2], i_mem.mem[addr+1], i_mem.mem[addr]};
  endfunction

  task automatic check_word(input string name, input conv_pkg::word_t got,
                            input conv_pkg::word_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_size(input string name, input conv_pkg::mem_size_e got,
                            input conv_pkg::mem_size_e exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "size mismatch");
    end
  endtask

  always @(posedge clk) begin : stall_gen
    logic [3:0] s;
    s = '0;
    if (stall_en) begin
      for (int i = 0; i < 4; i++) s[i] = lfsr_bit() & lfsr_bit(); // stall one cycle in four
    end
    stall <= s;
  end

  always @(negedge clk) begin : port_monitor
    conv_pkg::mem_size_e exp_size;
    if (rd_req_valid && rd_req_ready) begin
      // partial sums are the only word reads
      if ((rd_req.addr >= ofm_lo) && (rd_req.addr < ofm_hi)) exp_size = conv_pkg::SIZE_WORD;
      else exp_size = conv_pkg::SIZE_BYTE;
      check_size("rd_req.size", rd_req.size, exp_size);
    end
    if (wr_req_valid && wr_req_ready) begin
      check_bit("wr_addr inside ofm region", (wr_addr >= ofm_lo) && (wr_addr < ofm_hi), 1'b1);
    end
    if (wr_data_valid && wr_data_ready) wr_count++;
  end

  // bit 7 forced by address parity puts negative bytes in every lane
  task automatic fill_memory(input logic force_neg);
    logic [7:0] b;
    for (int a = 0; a < MEM_BYTES; a++) begin
      b = lfsr_byte();
      if (force_neg && ^a) b[7] = 1'b1;
      i_mem.mem[a] = b;
    end
  endtask

  task automatic compute_expected(input conv_pkg::conv_job_t j, input conv_pkg::conv_base_t b);
    int id;
    int od;
    int nic;
    int acc;
    int scaled;
    byte w;
    byte f;
    conv_pkg::word_t sum;
    id  = int'(j.ifm_dim);
    od  = int'(j.ofm_dim);
    nic = int'(j.ifm_depth);
    for (int oc = 0; oc < int'(j.ofm_depth); oc++) begin
      for (int oy = 0; oy < od; oy++) begin
        for (int ox = 0; ox < od; ox++) begin
          sum = '0;
          for (int ic = 0; ic < nic; ic++) begin
            acc = 0;
            for (int k = 0; k < WT_SIZE; k++) begin
              w = i_mem.mem[b.wt_base + (oc * nic + ic) * WT_SIZE + k];
              f = i_mem.mem[b.ifm_base + ic * id * id + (oy + k / WT_DIM) * id +
                            ox + k % WT_DIM];
              acc += w * f;
            end
            scaled = acc >>> conv_pkg::ACC_SHIFT; // per channel truncation
            sum = sum + conv_pkg::word_t'(scaled);
          end
          exp_words[(oc * od + oy) * od + ox] = sum;
        end
      end
    end
  endtask

  task automatic run_job(input conv_pkg::conv_job_t j, input conv_pkg::conv_base_t b);
    int n_words;
    n_words = int'(j.ofm_depth * j.ofm_dim * j.ofm_dim);
    compute_expected(j, b);
    ofm_lo   = b.ofm_base;
    ofm_hi   = b.ofm_base + 4 * n_words;
    wr_count = 0;
    check_bit("done before start", done, job_ran);
    @(posedge clk);
    job   <= j;
    base  <= b;
    start <= 1'b1;
    @(negedge clk);
    check_bit("done during start", done, 1'b0);
    check_bit("idle during start", idle, 1'b1);
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (!done) begin
      check_bit("idle while busy", idle, 1'b0);
      @(negedge clk);
    end
    job_ran = 1'b1;
    check_bit("idle after done", idle, 1'b1);
    check_word("ofm write count", conv_pkg::word_t'(wr_count),
               j.ofm_depth * j.ifm_depth * j.ofm_dim * j.ofm_dim);
    repeat (3) begin
      @(negedge clk);
      check_bit("done held", done, 1'b1);
    end
    for (int i = 0; i < n_words; i++) begin
      check_word("ofm word", read_word(b.ofm_base + 4 * i), exp_words[i]);
    end
  endtask

  function automatic conv_pkg::conv_job_t make_job(input int idim, input int ic, input int oc);
    return '{ifm_dim: idim, ifm_depth: ic, ofm_dim: idim - WT_DIM + 1, ofm_depth: oc};
  endfunction

  function automatic conv_pkg::conv_base_t make_base(input int ifm, input int wt, input int ofm);
    return '{ifm_base: ifm, wt_base: wt, ofm_base: ofm};
  endfunction

  task automatic check_reset_state();
    @(negedge clk);
    check_bit("idle", idle, 1'b1);
    check_bit("done", done, 1'b0);
    check_bit("rd_req_valid", rd_req_valid, 1'b0);
    check_bit("rd_data_ready", rd_data_ready, 1'b0);
    check_bit("wr_req_valid", wr_req_valid, 1'b0);
    check_bit("wr_data_valid", wr_data_valid, 1'b0);
  endtask

  task automatic test_single_channel();
    run_job(make_job(5, 1, 1), make_base('h000, 'h100, 'h200));
  endtask

  task automatic test_multi_input_channel();
    run_job(make_job(5, 3, 1), make_base('h010, 'h120, 'h240));
  endtask

  task automatic test_negative_bytes();
    fill_memory(1'b1);
    run_job(make_job(5, 2, 2), make_base('h041, 'h143, 'h280)); // unaligned bases
    for (int i = 0; i < 18; i++) prev_words[i] = read_word('h280 + 4 * i);
  endtask

  task automatic test_stalled_ports();
    for (int a = 'h280; a < 'h280 + 72; a++) i_mem.mem[a] = lfsr_byte(); // stale ofm
    stall_en = 1'b1;
    run_job(make_job(5, 2, 2), make_base('h041, 'h143, 'h280));
    stall_en = 1'b0;
    for (int i = 0; i < 18; i++) begin
      check_word("stalled ofm word", read_word('h280 + 4 * i), prev_words[i]);
    end
  endtask

  task automatic test_restart_new_bases();
    run_job(make_job(5, 2, 1), make_base('h302, 'h3a1, 'h3c0));
  endtask

  initial begin
    rst_n    = 1'b0;
    start    = 1'b0;
    job      = '0;
    base     = '0;
    stall    = '0;
    stall_en = 1'b0;
    job_ran  = 1'b0;
    ofm_lo   = '0;
    ofm_hi   = '0;
    wr_count = 0;
    fill_memory(1'b0);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    test_single_channel();
    test_multi_input_channel();
    test_negative_bytes();
    test_stalled_ports();
    test_restart_new_bases();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- sim.f
conv_pkg.sv
conv_shape.sv
conv_ctrl.sv
conv_addr_gen.sv
conv_window.sv
conv_mac.sv
conv_accel.sv
tb_conv_mem.sv
tb_conv_accel.sv
